/* tile_accel.f */
hdl/accel_pkg.sv
hdl/ctrl_unit.sv
hdl/rf_bank.sv
hdl/ldst_unit.sv
hdl/eu_vadd.sv
hdl/sdram_arbiter.sv
hdl/design_top.sv
tb/tb_design_top.sv

/* tb/tb_design_top.sv */
`timescale 1ns/1ns

module tb_design_top import accel_pkg::*; ();

logic        clk;
logic        i_reset;
cmd_t        i_h2f_pio32;
logic        i_h2f_write;
logic [31:0] o_f2h_pio32;
logic        o_f2h_write;
logic [7:0]  o_led;
logic        o_mem_req;
mem_req_t    o_mem_req_data;
logic        i_mem_ack;
data_t       i_mem_rdata;

status_t     status_w;

// sdram model state
data_t       mem_model [mem_addr_t];
logic        pend;
mem_req_t    pend_req;
int          wait_cnt;

// scoreboard
int          n_checks;
int          n_errors;
int          n_timeouts;
int          exp_done;
opcode_e     exp_last;
logic        exp_dropped;
logic [15:0] prev_cnt;

assign status_w = o_f2h_pio32;

design_top dut0 (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_h2f_pio32    (i_h2f_pio32),
    .i_h2f_write    (i_h2f_write),
    .o_f2h_pio32    (o_f2h_pio32),
    .o_f2h_write    (o_f2h_write),
    .o_led          (o_led),
    .o_mem_req      (o_mem_req),
    .o_mem_req_data (o_mem_req_data),
    .i_mem_ack      (i_mem_ack),
    .i_mem_rdata    (i_mem_rdata)
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

////////////////////////////////////////////////////////////
// sdram model
////////////////////////////////////////////////////////////

// one request at a time, ack 1 to 6 cycles later on the falling edge
initial begin
    i_mem_ack   = 1'b0;
    i_mem_rdata = '0;
    pend        = 1'b0;
    wait_cnt    = 0;
    forever begin
        @(negedge clk);
        i_mem_ack = 1'b0;
        if (i_reset) begin
            pend = 1'b0;
        end else begin
            if (pend) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    if (pend_req.we) begin
                        mem_model[pend_req.addr] = pend_req.wdata;
                    end else if (mem_model.exists(pend_req.addr)) begin
                        i_mem_rdata = mem_model[pend_req.addr];
                    end else begin
                        // untouched words read back as a pattern of the address
                        i_mem_rdata = {pend_req.addr, ~pend_req.addr, pend_req.addr, 4'h9};
                    end
                    i_mem_ack = 1'b1;
                    pend      = 1'b0;
                end
            end
            if (o_mem_req) begin
                if (pend) begin
                    n_errors++;
                    $display("%0t: sdram model got a second request before the ack", $time);
                end
                pend     = 1'b1;
                pend_req = o_mem_req_data;
                wait_cnt = 1 + $urandom % 6;
            end
        end
    end
end

////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////
task automatic check_data(input data_t got, input data_t exp, input string name);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_status(input status_t got, input status_t exp, input string name);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_led(input logic [7:0] got, input logic [7:0] exp, input string name);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string name);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
endtask

// host write pulse must follow every change of the completion count
always @(negedge clk) begin
    if (i_reset) begin
        prev_cnt <= '0;
    end else begin
        check_flag(o_f2h_write, status_w.done_cnt != prev_cnt, "o_f2h_write");
        prev_cnt <= status_w.done_cnt;
    end
end

////////////////////////////////////////////////////////////
// helpers
////////////////////////////////////////////////////////////

// each lane summed on its own, capped at 255
function automatic data_t lane_sum_clamped(input data_t a, input data_t b);
    data_t r;
    int    s;
    r = '0;
    for (int i = 0; i < LANES; i++) begin
        s = int'(a[8*i +: 8]) + int'(b[8*i +: 8]);
        if (s > 255) begin
            s = 255;
        end
        r[8*i +: 8] = lane_t'(s);
    end
    return r;
endfunction

function automatic data_t rand_word();
    return {$urandom, $urandom};
endfunction

// called on a falling edge, returns on the next one
task automatic send_cmd(input opcode_e op, input rf_addr_t dst, input rf_addr_t src,
                        input mem_addr_t addr);
    i_h2f_pio32 = '{op: op, dst: dst, src: src, addr: addr};
    i_h2f_write = 1'b1;
    @(negedge clk);
    i_h2f_write = 1'b0;
endtask

task automatic note_accepted(input opcode_e op);
    exp_done++;
    exp_last = op;
endtask

task automatic wait_idle(input string what);
    int n;
    n = 0;
    // 200 cycles is far above the slowest command
    while (status_w.busy && n < 200) begin
        @(negedge clk);
        n++;
    end
    if (status_w.busy) begin
        n_timeouts++;
        $display("%0t: engines still busy after %0d cycles in %s", $time, n, what);
    end
endtask

task automatic check_counters(input string what);
    status_t exp;
    exp = '{busy: 1'b0, dropped: exp_dropped, rsvd0: '0, last_op: exp_last,
            rsvd1: '0, done_cnt: 16'(exp_done)};
    check_status(status_w, exp, {"o_f2h_pio32 after ", what});
    check_led(o_led, 8'(exp_done), {"o_led after ", what});
endtask

// store a line and compare what reached the model memory
task automatic store_and_check(input rf_addr_t line, input mem_addr_t addr, input data_t exp,
                               input string what);
    send_cmd(OP_STORE, '0, line, addr);
    wait_idle(what);
    note_accepted(OP_STORE);
    if (!mem_model.exists(addr)) begin
        n_errors++;
        $display("%0t: store in %s never reached the sdram model", $time, what);
    end else begin
        check_data(mem_model[addr], exp, {"mem in ", what});
    end
endtask

////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////
task automatic test_load_store();
    data_t w;
    w = rand_word();
    mem_model[20'h10000] = w;
    send_cmd(OP_LOAD, 4'd1, '0, 20'h10000);
    wait_idle("load_store");
    note_accepted(OP_LOAD);
    store_and_check(4'd1, 20'h10100, w, "load_store");
    check_counters("load_store");
endtask

task automatic test_move();
    data_t w;
    w = rand_word();
    mem_model[20'h11000] = w;
    send_cmd(OP_LOAD, 4'd2, '0, 20'h11000);
    wait_idle("move load");
    note_accepted(OP_LOAD);
    send_cmd(OP_MOVE, 4'd3, 4'd2, '0);
    wait_idle("move");
    note_accepted(OP_MOVE);
    store_and_check(4'd3, 20'h11100, w, "move");
    check_counters("move");
endtask

// line 4 keeps the exec source lanes for the contention test too
task automatic test_exec();
    data_t src;
    data_t wt;
    src = 64'hF0_80_7F_01_FF_10_C8_00;
    wt  = 64'h20_80_01_FE_01_05_40_00;
    mem_model[20'h20000] = src;
    mem_model[20'h20001] = wt;
    send_cmd(OP_LOAD, 4'd4, '0, 20'h20000);
    wait_idle("exec load");
    note_accepted(OP_LOAD);
    send_cmd(OP_EXEC, 4'd5, 4'd4, 20'h20001);
    wait_idle("exec");
    note_accepted(OP_EXEC);
    store_and_check(4'd5, 20'h20002, lane_sum_clamped(src, wt), "exec");
    check_counters("exec");
endtask

// load and exec issued in consecutive cycles fight for the sdram port
task automatic test_contention();
    data_t     src;
    data_t     wl;
    data_t     wx;
    mem_addr_t r;
    src = 64'hF0_80_7F_01_FF_10_C8_00;
    for (int k = 0; k < 4; k++) begin
        r  = mem_addr_t'(k);
        wl = rand_word();
        wx = rand_word();
        mem_model[20'h30000 + r] = wl;
        mem_model[20'h31000 + r] = wx;
        send_cmd(OP_LOAD, 4'd8, '0, 20'h30000 + r);
        send_cmd(OP_EXEC, 4'd7, 4'd4, 20'h31000 + r);
        wait_idle("contention");
        note_accepted(OP_LOAD);
        note_accepted(OP_EXEC);
        store_and_check(4'd8, 20'h32000 + r, wl, "contention load");
        store_and_check(4'd7, 20'h33000 + r, lane_sum_clamped(src, wx), "contention exec");
    end
    check_counters("contention");
endtask

// second load while the first is busy must be dropped
task automatic test_dropped();
    data_t w;
    w = rand_word();
    mem_model[20'h40000] = w;
    mem_model[20'h40001] = rand_word();
    send_cmd(OP_LOAD, 4'd9, '0, 20'h40000);
    send_cmd(OP_LOAD, 4'd10, '0, 20'h40001);
    wait_idle("dropped");
    note_accepted(OP_LOAD);
    exp_dropped = 1'b1;
    check_counters("dropped");
    store_and_check(4'd9, 20'h40100, w, "dropped first load");
    // line 10 untouched since reset
    store_and_check(4'd10, 20'h40101, '0, "dropped second load");
    check_counters("dropped stores");
endtask

////////////////////////////////////////////////////////////
// main sequence
////////////////////////////////////////////////////////////
initial begin
    void'($urandom(62));
    n_checks    = 0;
    n_errors    = 0;
    n_timeouts  = 0;
    exp_done    = 0;
    exp_last    = OP_NOP;
    exp_dropped = 1'b0;
    i_reset     = 1'b1;
    i_h2f_pio32 = '0;
    i_h2f_write = 1'b0;
    repeat (16) @(negedge clk);
    i_reset = 1'b0;
    @(negedge clk);

    // everything quiet out of reset
    check_status(status_w, '0, "o_f2h_pio32 after reset");
    check_flag(o_mem_req, 1'b0, "o_mem_req after reset");
    check_led(o_led, 8'h00, "o_led after reset");

    test_load_store();
    test_move();
    test_exec();
    test_contention();
    test_dropped();

    repeat (4) @(negedge clk);
    $display("summary: %0d checks, %0d errors, %0d timeouts", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
        $display("TB PASSED");
    end else begin
        $display("TB FAILED");
    end
    $finish;
end

endmodule

/* hdl/design_top.sv */
`timescale 1ns/1ns

module design_top import accel_pkg::*; (
    input  logic        clk,
    input  logic        i_reset,

    // mmio
    input  logic [31:0] i_h2f_pio32,
    input  logic        i_h2f_write,
    output logic [31:0] o_f2h_pio32,
    output logic        o_f2h_write,

    output logic [7:0]  o_led,

    // sdram
    output logic        o_mem_req,
    output mem_req_t    o_mem_req_data,
    input  logic        i_mem_ack,
    input  data_t       i_mem_rdata
);

////////////////////////////////////////////////////////////
// signals
////////////////////////////////////////////////////////////
cmd_t           host_cmd;
status_t        status;
cmd_t           cmd;
logic           ldst_start, move_start, eu_start;
logic           ldst_done, move_done, eu_done;

// rf ports
rf_addr_t       ldst_raddr, ldst_waddr, eu_raddr, eu_waddr;
data_t          ldst_rdata, ldst_wdata, eu_rdata, eu_wdata;
logic           ldst_we, eu_we;

// arbiter ports
logic [1:0]     req_lvl, grant, ack;
mem_req_t [1:0] req_data;
data_t          arb_rdata;

assign host_cmd    = i_h2f_pio32;
assign o_f2h_pio32 = status;
assign o_led       = status.done_cnt[7:0];

////////////////////////////////////////////////////////////
// control unit and register file
////////////////////////////////////////////////////////////
ctrl_unit i_ctrl_unit (
    .clk (clk), .i_reset (i_reset),
    .i_h2f_pio32 (host_cmd), .i_h2f_write (i_h2f_write),
    .i_ldst_done (ldst_done), .i_move_done (move_done), .i_eu_done (eu_done),
    .o_cmd (cmd), .o_ldst_start (ldst_start), .o_move_start (move_start),
    .o_eu_start (eu_start), .o_status (status), .o_f2h_write (o_f2h_write)
);

rf_bank i_rf_bank (
    .clk (clk), .i_reset (i_reset),
    .i_cmd (cmd), .i_move_start (move_start), .o_move_done (move_done),
    .i_ldst_raddr (ldst_raddr), .o_ldst_rdata (ldst_rdata), .i_ldst_we (ldst_we),
    .i_ldst_waddr (ldst_waddr), .i_ldst_wdata (ldst_wdata),
    .i_eu_raddr (eu_raddr), .o_eu_rdata (eu_rdata), .i_eu_we (eu_we),
    .i_eu_waddr (eu_waddr), .i_eu_wdata (eu_wdata)
);

////////////////////////////////////////////////////////////
// engines and sdram arbiter
////////////////////////////////////////////////////////////
ldst_unit i_ldst_unit (
    .clk (clk), .i_reset (i_reset),
    .i_start (ldst_start), .i_cmd (cmd), .o_done (ldst_done),
    .o_rf_raddr (ldst_raddr), .i_rf_rdata (ldst_rdata), .o_rf_we (ldst_we),
    .o_rf_waddr (ldst_waddr), .o_rf_wdata (ldst_wdata),
    .o_mem_req_lvl (req_lvl[0]), .o_mem_req_data (req_data[0]),
    .i_mem_grant (grant[0]), .i_mem_ack (ack[0]), .i_mem_rdata (arb_rdata)
);

eu_vadd i_eu_vadd (
    .clk (clk), .i_reset (i_reset),
    .i_start (eu_start), .i_cmd (cmd), .o_done (eu_done),
    .o_rf_raddr (eu_raddr), .i_rf_rdata (eu_rdata), .o_rf_we (eu_we),
    .o_rf_waddr (eu_waddr), .o_rf_wdata (eu_wdata),
    .o_mem_req_lvl (req_lvl[1]), .o_mem_req_data (req_data[1]),
    .i_mem_grant (grant[1]), .i_mem_ack (ack[1]), .i_mem_rdata (arb_rdata)
);

sdram_arbiter i_sdram_arbiter (
    .clk (clk), .i_reset (i_reset),
    .i_req (req_lvl), .i_req_data (req_data),
    .o_grant (grant), .o_ack (ack), .o_rdata (arb_rdata),
    .o_mem_req (o_mem_req), .o_mem_req_data (o_mem_req_data),
    .i_mem_ack (i_mem_ack), .i_mem_rdata (i_mem_rdata)
);

endmodule

/* hdl/sdram_arbiter.sv */
`timescale 1ns/1ns

module sdram_arbiter import accel_pkg::*; (
    input  logic           clk,
    input  logic           i_reset,

    // requesters, port 0 ldst and port 1 eu
    input  logic [1:0]     i_req,
    input  mem_req_t [1:0] i_req_data,
    output logic [1:0]     o_grant,
    output logic [1:0]     o_ack,
    output data_t          o_rdata,

    // sdram side
    output logic           o_mem_req,
    output mem_req_t       o_mem_req_data,
    input  logic           i_mem_ack,
    input  data_t          i_mem_rdata
);

logic busy;
// owner of the bus, also the port served last
logic owner;
logic pick;

// both asking so take the port not served last
assign pick = (i_req == 2'b11) ? ~owner : i_req[1];

always_ff @(posedge clk) begin
    if (i_reset) begin
        busy      <= 1'b0;
        owner     <= 1'b0;
        o_grant   <= '0;
        o_mem_req <= 1'b0;
    end else begin
        o_grant   <= '0;
        o_mem_req <= 1'b0;
        if (!busy && |i_req) begin
            // grant and sdram request go out together
            o_grant[pick] <= 1'b1;
            o_mem_req     <= 1'b1;
            busy          <= 1'b1;
            owner         <= pick;
        end else if (busy && i_mem_ack) begin
            busy <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (!busy && |i_req) begin
        o_mem_req_data <= i_req_data[pick];
    end
end

// ack only to the owner
assign o_ack   = (busy && i_mem_ack) ? (owner ? 2'b10 : 2'b01) : 2'b00;
assign o_rdata = i_mem_rdata;

a_grant_onehot: assert property (@(posedge clk) disable iff (i_reset)
    $onehot0(o_grant))
    else $error("grant to both ports");

a_ack_outstanding: assert property (@(posedge clk) disable iff (i_reset)
    i_mem_ack |-> busy)
    else $error("sdram ack with nothing outstanding");

endmodule

/* hdl/eu_vadd.sv */
`timescale 1ns/1ns

module eu_vadd import accel_pkg::*; (
    input  logic     clk,
    input  logic     i_reset,

    input  logic     i_start,
    input  cmd_t     i_cmd,
    output logic     o_done,

    // register file port
    output rf_addr_t o_rf_raddr,
    input  data_t    i_rf_rdata,
    output logic     o_rf_we,
    output rf_addr_t o_rf_waddr,
    output data_t    o_rf_wdata,

    // arbiter port
    output logic     o_mem_req_lvl,
    output mem_req_t o_mem_req_data,
    input  logic     i_mem_grant,
    input  logic     i_mem_ack,
    input  data_t    i_mem_rdata
);

ctrl_state_e state;
cmd_t        cmd_q;
data_t       sum_q;

// lane-wise add, clamp at 255
function automatic data_t sat_add(input data_t a, input data_t b);
    lane_t                la;
    lane_t                lb;
    logic [$bits(lane_t):0] s;
    data_t                r;
    for (int i = 0; i < LANES; i++) begin
        la = a[i*$bits(lane_t) +: $bits(lane_t)];
        lb = b[i*$bits(lane_t) +: $bits(lane_t)];
        s  = {1'b0, la} + {1'b0, lb};
        // carry out means overflow
        r[i*$bits(lane_t) +: $bits(lane_t)] = s[$bits(lane_t)] ? '1 : s[$bits(lane_t)-1:0];
    end
    return r;
endfunction

////////////////////////////////////////////////////////////
// fsm
////////////////////////////////////////////////////////////
always_ff @(posedge clk) begin
    if (i_reset) begin
        state <= IDLE;
    end else begin
        case (state)
            IDLE:    if (i_start) state <= REQ;
            REQ:     if (i_mem_grant) state <= WAIT;
            // weight word arrives with the ack
            WAIT:    if (i_mem_ack) state <= WRITE;
            WRITE:   state <= IDLE;
            default: state <= IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == IDLE && i_start) begin
        cmd_q <= i_cmd;
    end
    // add against the source line as it stands at the ack
    if (state == WAIT && i_mem_ack) begin
        sum_q <= sat_add(i_rf_rdata, i_mem_rdata);
    end
end

////////////////////////////////////////////////////////////
// outputs
////////////////////////////////////////////////////////////

// read only weight fetch
assign o_mem_req_lvl  = (state == REQ);
assign o_mem_req_data = '{we: 1'b0, addr: cmd_q.addr, wdata: '0};

assign o_rf_raddr = cmd_q.src;
assign o_rf_we    = (state == WRITE);
assign o_rf_waddr = cmd_q.dst;
assign o_rf_wdata = sum_q;

// done with the rf write
assign o_done = (state == WRITE);

endmodule

/* hdl/ldst_unit.sv */
`timescale 1ns/1ns

module ldst_unit import accel_pkg::*; (
    input  logic     clk,
    input  logic     i_reset,

    input  logic     i_start,
    input  cmd_t     i_cmd,
    output logic     o_done,

    // register file port
    output rf_addr_t o_rf_raddr,
    input  data_t    i_rf_rdata,
    output logic     o_rf_we,
    output rf_addr_t o_rf_waddr,
    output data_t    o_rf_wdata,

    // arbiter port
    output logic     o_mem_req_lvl,
    output mem_req_t o_mem_req_data,
    input  logic     i_mem_grant,
    input  logic     i_mem_ack,
    input  data_t    i_mem_rdata
);

ctrl_state_e state;
cmd_t        cmd_q;
data_t       rdata_q;
logic        is_store;

assign is_store = (cmd_q.op == OP_STORE);

////////////////////////////////////////////////////////////
// fsm
////////////////////////////////////////////////////////////
always_ff @(posedge clk) begin
    if (i_reset) begin
        state <= IDLE;
    end else begin
        case (state)
            IDLE:    if (i_start) state <= REQ;
            // level held until the arbiter picks us
            REQ:     if (i_mem_grant) state <= WAIT;
            // store is finished at the ack
            WAIT:    if (i_mem_ack) state <= is_store ? IDLE : WRITE;
            WRITE:   state <= IDLE;
            default: state <= IDLE;
        endcase
    end
end

// own copy of the command
always_ff @(posedge clk) begin
    if (state == IDLE && i_start) begin
        cmd_q <= i_cmd;
    end
    if (state == WAIT && i_mem_ack) begin
        rdata_q <= i_mem_rdata;
    end
end

////////////////////////////////////////////////////////////
// outputs
////////////////////////////////////////////////////////////

// store data comes straight from the rf line
assign o_rf_raddr     = cmd_q.src;
assign o_mem_req_lvl  = (state == REQ);
assign o_mem_req_data = '{we: is_store, addr: cmd_q.addr, wdata: i_rf_rdata};

// load result lands the cycle after the ack
assign o_rf_we    = (state == WRITE);
assign o_rf_waddr = cmd_q.dst;
assign o_rf_wdata = rdata_q;

assign o_done = (state == WRITE) || (state == WAIT && i_mem_ack && is_store);

endmodule

/* hdl/rf_bank.sv */
`timescale 1ns/1ns

module rf_bank import accel_pkg::*; (
    input  logic     clk,
    input  logic     i_reset,

    // move engine control
    input  cmd_t     i_cmd,
    input  logic     i_move_start,
    output logic     o_move_done,

    // ldst port
    input  rf_addr_t i_ldst_raddr,
    output data_t    o_ldst_rdata,
    input  logic     i_ldst_we,
    input  rf_addr_t i_ldst_waddr,
    input  data_t    i_ldst_wdata,

    // eu port
    input  rf_addr_t i_eu_raddr,
    output data_t    o_eu_rdata,
    input  logic     i_eu_we,
    input  rf_addr_t i_eu_waddr,
    input  data_t    i_eu_wdata
);

data_t    lines [2**RF_ADDR_W];
data_t    move_buf;
rf_addr_t move_dst;
logic     move_wr;

// async reads
assign o_ldst_rdata = lines[i_ldst_raddr];
assign o_eu_rdata   = lines[i_eu_raddr];

////////////////////////////////////////////////////////////
// move engine
////////////////////////////////////////////////////////////

// cycle 0 latch source, cycle 1 write dest, cycle 2 done
always_ff @(posedge clk) begin
    if (i_reset) begin
        move_wr     <= 1'b0;
        o_move_done <= 1'b0;
    end else begin
        move_wr     <= i_move_start;
        o_move_done <= move_wr;
    end
end

always_ff @(posedge clk) begin
    if (i_move_start) begin
        move_buf <= lines[i_cmd.src];
        move_dst <= i_cmd.dst;
    end
end

////////////////////////////////////////////////////////////
// write ports
////////////////////////////////////////////////////////////

// later statement wins so move beats ldst beats eu
always_ff @(posedge clk) begin
    if (i_reset) begin
        lines <= '{default: '0};
    end else begin
        if (i_eu_we) begin
            lines[i_eu_waddr] <= i_eu_wdata;
        end
        if (i_ldst_we) begin
            lines[i_ldst_waddr] <= i_ldst_wdata;
        end
        if (move_wr) begin
            lines[move_dst] <= move_buf;
        end
    end
end

// engines working on the same line is a host ordering bug
a_no_write_clash: assert property (@(posedge clk) disable iff (i_reset)
    !(move_wr && i_ldst_we && move_dst == i_ldst_waddr) &&
    !(move_wr && i_eu_we && move_dst == i_eu_waddr) &&
    !(i_ldst_we && i_eu_we && i_ldst_waddr == i_eu_waddr))
    else $error("two engines wrote the same line");

endmodule

/* hdl/ctrl_unit.sv */
`timescale 1ns/1ns

module ctrl_unit import accel_pkg::*; (
    input  logic    clk,
    input  logic    i_reset,

    // host command port
    input  cmd_t    i_h2f_pio32,
    input  logic    i_h2f_write,

    // engine completion
    input  logic    i_ldst_done,
    input  logic    i_move_done,
    input  logic    i_eu_done,

    // engine dispatch
    output cmd_t    o_cmd,
    output logic    o_ldst_start,
    output logic    o_move_start,
    output logic    o_eu_start,

    output status_t o_status,
    output logic    o_f2h_write
);

////////////////////////////////////////////////////////////
// decode
////////////////////////////////////////////////////////////
logic        want_ldst, want_move, want_eu, want_nop;
logic        take_ldst, take_move, take_eu, accept;
logic        ldst_busy, move_busy, eu_busy;
logic        nop_done;
logic        dropped;
opcode_e     last_op;
logic [15:0] done_cnt;
logic [2:0]  done_inc;

always_comb begin
    want_ldst = 1'b0;
    want_move = 1'b0;
    want_eu   = 1'b0;
    want_nop  = 1'b0;
    case (i_h2f_pio32.op)
        OP_NOP:            want_nop  = i_h2f_write;
        OP_LOAD, OP_STORE: want_ldst = i_h2f_write;
        OP_MOVE:           want_move = i_h2f_write;
        OP_EXEC:           want_eu   = i_h2f_write;
        // unknown opcodes fall through and get dropped
        default:           want_nop  = 1'b0;
    endcase
end

// engine must be idle to take the command
assign take_ldst = want_ldst && !ldst_busy;
assign take_move = want_move && !move_busy;
assign take_eu   = want_eu && !eu_busy;
assign accept    = take_ldst | take_move | take_eu | want_nop;

// up to four completions in one cycle
assign done_inc = 3'(i_ldst_done) + 3'(i_move_done) + 3'(i_eu_done) + 3'(nop_done);

////////////////////////////////////////////////////////////
// dispatch and bookkeeping
////////////////////////////////////////////////////////////
always_ff @(posedge clk) begin
    if (i_reset) begin
        o_ldst_start <= 1'b0;
        o_move_start <= 1'b0;
        o_eu_start   <= 1'b0;
        nop_done     <= 1'b0;
        ldst_busy    <= 1'b0;
        move_busy    <= 1'b0;
        eu_busy      <= 1'b0;
        dropped      <= 1'b0;
        last_op      <= OP_NOP;
        done_cnt     <= '0;
        o_f2h_write  <= 1'b0;
    end else begin
        // start pulses one cycle after the host write
        o_ldst_start <= take_ldst;
        o_move_start <= take_move;
        o_eu_start   <= take_eu;
        nop_done     <= want_nop;
        // busy from start until the engine's done
        ldst_busy    <= take_ldst | (ldst_busy & ~i_ldst_done);
        move_busy    <= take_move | (move_busy & ~i_move_done);
        eu_busy      <= take_eu | (eu_busy & ~i_eu_done);
        // sticky until reset
        if (i_h2f_write && !accept) begin
            dropped <= 1'b1;
        end
        if (accept) begin
            last_op <= i_h2f_pio32.op;
        end
        done_cnt    <= done_cnt + 16'(done_inc);
        // tell the host the count moved
        o_f2h_write <= |done_inc;
    end
end

// held command for the engine being started
always_ff @(posedge clk) begin
    if (accept) begin
        o_cmd <= i_h2f_pio32;
    end
end

assign o_status = '{
    busy:     ldst_busy | move_busy | eu_busy,
    dropped:  dropped,
    rsvd0:    '0,
    last_op:  last_op,
    rsvd1:    '0,
    done_cnt: done_cnt
};

a_one_start: assert property (@(posedge clk) disable iff (i_reset)
    $onehot0({o_ldst_start, o_move_start, o_eu_start}))
    else $error("more than one engine started in a cycle");

endmodule

/* hdl/accel_pkg.sv */
package accel_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // one line = one sdram word
    localparam int DATA_W     = 64;
    // 8-bit lanes per line
    localparam int LANES      = 8;
    // 16 register file lines
    localparam int RF_ADDR_W  = 4;
    // sdram word address
    localparam int MEM_ADDR_W = 20;

    ////////////////////////////////////////////////////////////
    // basic types
    ////////////////////////////////////////////////////////////

    typedef logic [DATA_W-1:0]         data_t;
    typedef logic [DATA_W/LANES-1:0]   lane_t;
    typedef logic [RF_ADDR_W-1:0]      rf_addr_t;
    typedef logic [MEM_ADDR_W-1:0]     mem_addr_t;

    // host command opcodes, top nibble of the command word
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_LOAD  = 4'd1,
        OP_STORE = 4'd2,
        OP_MOVE  = 4'd3,
        OP_EXEC  = 4'd4
    } opcode_e;

    // 32-bit host command
    typedef struct packed {
        opcode_e   op;
        rf_addr_t  dst;
        rf_addr_t  src;
        mem_addr_t addr;
    } cmd_t;

    // one sdram access
    typedef struct packed {
        logic      we;
        mem_addr_t addr;
        data_t     wdata;
    } mem_req_t;

    // status word seen by the host
    typedef struct packed {
        logic        busy;
        logic        dropped;
        logic [1:0]  rsvd0;
        opcode_e     last_op;
        logic [7:0]  rsvd1;
        logic [15:0] done_cnt;
    } status_t;

    // engine fsm states (ldst and eu)
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        WRITE
    } ctrl_state_e;

endpackage
